// File: vlog.f
+incdir+verilog
verilog/l1d_pkg.sv
verilog/l1d_tag_stage.sv
verilog/l1d_data_stage.sv
verilog/l1d_ctrl_regs.sv
verilog/l1d_bus_unit.sv
verilog/l1d_top.sv
tests/l1d_mem_model.sv
tests/l1d_tb.sv

// File: Bender.yml
package:
  name: l1d_cache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/l1d_pkg.sv
      - verilog/l1d_tag_stage.sv
      - verilog/l1d_data_stage.sv
      - verilog/l1d_ctrl_regs.sv
      - verilog/l1d_bus_unit.sv
      - verilog/l1d_top.sv
  - target: test
    files:
      - tests/l1d_mem_model.sv
      - tests/l1d_tb.sv

// File: tests/l1d_tb.sv
/*
 * Testbench for the L1 data cache: stimulus table with retries on rollback,
 * response and memory checks, control register counter checks
 */
`timescale 1ns/100ps

module l1d_tb;
	import l1d_pkg::*;

	localparam logic [31:0] IMAGE_KEY = 32'h5a3c_96e1;
	localparam int RETRY_LIMIT = 40;
	localparam int IDLE_TIMEOUT = 200;

	typedef struct packed {
		l1d_op_t op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] rdata;
		l1d_status_t status;
		logic cold;
	} step_t;

	logic clk;
	logic reset;
	l1d_req_t req;
	l1d_rsp_t rsp;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [31:0] wb_adr;
	logic [3:0] wb_sel;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;

	step_t steps[$];
	logic [31:0] shadow[logic [29:0]];
	logic [31:0] stored_words[$];
	int check_count;
	int value_errors;
	int other_errors;
	int hit_total;
	int miss_total;
	int store_total;
	logic enable_seen;

	l1d_top dut0(.clk, .reset, .req, .rsp, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel,
		.wb_dat_w, .wb_dat_r, .wb_ack);

	l1d_mem_model #(.IMAGE_KEY(IMAGE_KEY)) mem0(.clk, .reset, .cyc(wb_cyc), .stb(wb_stb),
		.we(wb_we), .adr(wb_adr), .sel(wb_sel), .dat_w(wb_dat_w), .dat_r(wb_dat_r),
		.ack(wb_ack));

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic is_load_op(input l1d_op_t op);
		return op inside {OP_LOAD_B, OP_LOAD_H, OP_LOAD_W};
	endfunction

	function automatic logic [31:0] creg_addr(input l1d_creg_t index);
		return {28'd0, index, 2'b00};
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		if (shadow.exists(addr[31:2]))
			return shadow[addr[31:2]];
		return {addr[31:2], 2'b00} ^ IMAGE_KEY;
	endfunction

	// Little endian, zero extended
	function automatic logic [31:0] expected_load(input l1d_op_t op, input logic [31:0] addr);
		logic [31:0] w;
		w = expected_word(addr);
		if (op == OP_LOAD_B)
			return (w >> (8 * addr[1:0])) & 32'h0000_00ff;
		if (op == OP_LOAD_H)
			return (w >> (16 * addr[1])) & 32'h0000_ffff;
		return w;
	endfunction

	task automatic record_store(input l1d_op_t op, input logic [31:0] addr,
		input logic [31:0] wdata);
		logic [31:0] w;
		w = expected_word(addr);
		case (op)
			OP_STORE_B: w[8 * addr[1:0] +: 8] = wdata[7:0];
			OP_STORE_H: w[16 * addr[1] +: 16] = wdata[15:0];
			default: w = wdata;
		endcase
		shadow[addr[31:2]] = w;
		stored_words.push_back({addr[31:2], 2'b00});
	endtask

	task automatic add_step(input l1d_op_t op, input logic [31:0] addr,
		input logic [31:0] wdata, input l1d_status_t status, input logic cold);
		step_t s;
		s = '{op: op, addr: addr, wdata: wdata, rdata: '0, status: status, cold: cold};
		if (is_load_op(op))
			s.rdata = expected_load(op, addr);
		else if (op inside {OP_STORE_B, OP_STORE_H, OP_STORE_W} && status == ST_OK)
			record_store(op, addr, wdata);
		steps.push_back(s);
	endtask

	task automatic build_table();
		// Cold word load, then every byte and halfword of a second line
		add_step(OP_LOAD_W, 32'h0000_0110, '0, ST_OK, 1'b1);
		for (int b = 0; b < 16; b++)
			add_step(OP_LOAD_B, 32'h0000_0220 + b, '0, ST_OK, 1'b0);
		for (int h = 0; h < 16; h += 2)
			add_step(OP_LOAD_H, 32'h0000_0220 + h, '0, ST_OK, 1'b0);

		// Stores into the resident line, then read back
		add_step(OP_STORE_B, 32'h0000_0111, 32'h0000_00a5, ST_OK, 1'b0);
		add_step(OP_STORE_H, 32'h0000_0116, 32'h0000_beef, ST_OK, 1'b0);
		add_step(OP_STORE_W, 32'h0000_0118, 32'h1234_5678, ST_OK, 1'b0);
		add_step(OP_STORE_B, 32'h0000_011f, 32'h0000_003c, ST_OK, 1'b0);
		for (int w = 0; w < 16; w += 4)
			add_step(OP_LOAD_W, 32'h0000_0110 + w, '0, ST_OK, 1'b0);
		add_step(OP_LOAD_H, 32'h0000_0116, '0, ST_OK, 1'b0);
		add_step(OP_LOAD_B, 32'h0000_0111, '0, ST_OK, 1'b0);

		// No allocate, so the later fill must bring the stored word in
		add_step(OP_STORE_W, 32'h0000_0550, 32'hcafe_f00d, ST_OK, 1'b0);
		add_step(OP_LOAD_W, 32'h0000_0550, '0, ST_OK, 1'b0);

		// Three lines competing for set 4 keep evicting each other under LRU
		for (int r = 0; r < 2; r++)
		begin
			for (int t = 1; t <= 3; t++)
				add_step(OP_LOAD_W, (32'(t) << 28) | 32'h0000_0044, '0, ST_OK, 1'b1);
		end

		add_step(OP_CREG_WRITE, creg_addr(CREG_HITS), '0, ST_OK, 1'b0);
		add_step(OP_CREG_WRITE, creg_addr(CREG_MISSES), '0, ST_OK, 1'b0);
		add_step(OP_CREG_WRITE, creg_addr(CREG_STORES), '0, ST_OK, 1'b0);
		add_step(OP_CREG_WRITE, creg_addr(CREG_ENABLE), 32'd0, ST_OK, 1'b0);
		add_step(OP_CREG_READ, creg_addr(CREG_ENABLE), '0, ST_OK, 1'b0);
		add_step(OP_LOAD_W, 32'h0000_0110, '0, ST_ROLLBACK, 1'b0);
		add_step(OP_LOAD_B, 32'h0000_0224, '0, ST_ROLLBACK, 1'b0);
		add_step(OP_CREG_WRITE, creg_addr(CREG_ENABLE), 32'd1, ST_OK, 1'b0);
		add_step(OP_CREG_READ, creg_addr(CREG_ENABLE), '0, ST_OK, 1'b0);
		add_step(OP_LOAD_W, 32'h0000_0110, '0, ST_OK, 1'b0);
		add_step(OP_LOAD_B, 32'h0000_0224, '0, ST_OK, 1'b0);
		add_step(OP_LOAD_W, 32'h0000_0330, '0, ST_OK, 1'b0);
		add_step(OP_STORE_H, 32'h0000_0332, 32'h0000_7788, ST_OK, 1'b0);
		add_step(OP_LOAD_W, 32'h0000_0330, '0, ST_OK, 1'b0);
		add_step(OP_LOAD_W, 32'h1000_0044, '0, ST_OK, 1'b0);
		add_step(OP_CREG_READ, creg_addr(CREG_HITS), '0, ST_OK, 1'b0);
		add_step(OP_CREG_READ, creg_addr(CREG_MISSES), '0, ST_OK, 1'b0);
		add_step(OP_CREG_READ, creg_addr(CREG_STORES), '0, ST_OK, 1'b0);
	endtask

	// Response is registered two cycles after the request
	task automatic send_request(input step_t s, output l1d_rsp_t got);
		@(posedge clk);
		req <= '{valid: 1'b1, op: s.op, addr: s.addr, wdata: s.wdata};
		@(posedge clk);
		req.valid <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		got = rsp;
	endtask

	task automatic wait_bus_idle(output logic ok);
		int idle_run;
		int cycles;
		idle_run = 0;
		cycles = 0;
		ok = 1'b1;
		while (idle_run < 4 && ok)
		begin
			@(negedge clk);
			idle_run = wb_cyc ? 0 : idle_run + 1;
			cycles++;
			if (cycles > IDLE_TIMEOUT)
			begin
				$display("the Wishbone bus did not go idle within %0d cycles", IDLE_TIMEOUT);
				ok = 1'b0;
			end
		end
	endtask

	function automatic l1d_rsp_t expected_rsp(input step_t s);
		l1d_rsp_t e;
		e = '{valid: 1'b1, status: s.status, op: s.op, rdata: s.rdata};
		if (s.op == OP_CREG_READ)
		begin
			case (l1d_creg_t'(s.addr[3:2]))
				CREG_ENABLE: e.rdata = {31'd0, enable_seen};
				CREG_HITS: e.rdata = hit_total;
				CREG_MISSES: e.rdata = miss_total;
				default: e.rdata = store_total;
			endcase
		end
		return e;
	endfunction

	task automatic check_rsp(input l1d_rsp_t got, input l1d_rsp_t exp);
		check_count++;
		if (got.valid !== 1'b1)
		begin
			$display("no valid response came two cycles after the request at %0t", $time);
			other_errors++;
		end
		if (got.status !== exp.status)
		begin
			$display("error at %0t: rsp.status got %s expected %s", $time,
				got.status.name(), exp.status.name());
			value_errors++;
		end
		if (got.op !== exp.op)
		begin
			$display("error at %0t: rsp.op got %s expected %s", $time,
				got.op.name(), exp.op.name());
			value_errors++;
		end
		if (exp.status == ST_OK && (is_load_op(exp.op) || exp.op == OP_CREG_READ)
			&& got.rdata !== exp.rdata)
		begin
			$display("error at %0t: rsp.rdata got %h expected %h", $time, got.rdata, exp.rdata);
			value_errors++;
		end
	endtask

	task automatic check_wb_word(input logic [31:0] addr, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp)
		begin
			$display("error at %0t: mem0 word %h got %h expected %h", $time, addr, got, exp);
			value_errors++;
		end
	endtask

	// The bus is idle before every first attempt, so a rollback there is a miss
	task automatic note_first_attempt(input step_t s, input l1d_rsp_t got);
		if (is_load_op(s.op) && got.status == ST_ROLLBACK)
			miss_total++;
		if (s.cold && got.status == ST_OK)
		begin
			$display("load at %h hit a line that should not be resident", s.addr);
			other_errors++;
		end
	endtask

	task automatic track_effects(input step_t s, input l1d_rsp_t got);
		if (got.status == ST_OK)
		begin
			if (is_load_op(s.op))
				hit_total++;
			else if (s.op inside {OP_STORE_B, OP_STORE_H, OP_STORE_W})
				store_total++;
			else if (s.op == OP_CREG_WRITE)
			begin
				case (l1d_creg_t'(s.addr[3:2]))
					CREG_ENABLE: enable_seen = s.wdata[0];
					CREG_HITS: hit_total = 0;
					CREG_MISSES: miss_total = 0;
					default: store_total = 0;
				endcase
			end
		end
	endtask

	initial
	begin
		step_t s;
		l1d_rsp_t got;
		int attempts;
		logic ok;
		logic timed_out;
		req = '0;
		reset = 1'b1;
		check_count = 0;
		value_errors = 0;
		other_errors = 0;
		hit_total = 0;
		miss_total = 0;
		store_total = 0;
		enable_seen = 1'b1;
		timed_out = 1'b0;
		build_table();
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < steps.size() && !timed_out; i++)
		begin
			s = steps[i];
			wait_bus_idle(ok);
			timed_out = !ok;
			if (ok)
			begin
				attempts = 0;
				do
				begin
					send_request(s, got);
					attempts++;
					if (attempts == 1)
						note_first_attempt(s, got);
				end
				while (s.status == ST_OK && got.status == ST_ROLLBACK
					&& attempts < RETRY_LIMIT);

				if (s.status == ST_OK && got.status == ST_ROLLBACK)
				begin
					$display("request %0d to address %h was rolled back %0d times in a row",
						i, s.addr, attempts);
					timed_out = 1'b1;
				end
				else
				begin
					check_rsp(got, expected_rsp(s));
					track_effects(s, got);
				end
			end
		end

		// Memory must hold every word that a store touched
		if (!timed_out)
		begin
			wait_bus_idle(ok);
			timed_out = !ok;
			foreach (stored_words[k])
				check_wb_word(stored_words[k], mem0.word_at(stored_words[k]),
					expected_word(stored_words[k]));
		end

		$display("checks %0d, value errors %0d, other failures %0d, timeout %0d",
			check_count, value_errors, other_errors, timed_out);
		if (value_errors == 0 && other_errors == 0 && !timed_out)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end
endmodule

// File: tests/l1d_mem_model.sv
/*
 * Wishbone classic slave memory: computed initial image, written words kept
 * aside, ack after a random delay of zero to three cycles
 */
`timescale 1ns/100ps

module l1d_mem_model #(
	parameter logic [31:0] IMAGE_KEY = 32'h0)
(
	input clk,
	input reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [31:0] adr,
	input logic [3:0] sel,
	input logic [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic ack);

	localparam logic [31:0] SEED = 32'he962_56c4;

	logic [31:0] mem[logic [29:0]];

	// Untouched words read as their own address mixed with the key
	function automatic logic [31:0] word_at(input logic [31:0] a);
		if (mem.exists(a[31:2]))
			return mem[a[31:2]];
		return {a[31:2], 2'b00} ^ IMAGE_KEY;
	endfunction

	initial
	begin
		logic [31:0] w;
		int delay;
		void'($urandom(SEED));
		ack = 1'b0;
		dat_r = '0;
		forever
		begin
			@(posedge clk);
			ack <= 1'b0;
			// A beat already acked is still visible here for one edge
			if (!reset && cyc && stb && !ack)
			begin
				delay = $urandom % 4;
				repeat (delay) @(posedge clk);
				if (we)
				begin
					w = word_at(adr);
					for (int b = 0; b < 4; b++)
					begin
						if (sel[b])
							w[b * 8 +: 8] = dat_w[b * 8 +: 8];
					end
					mem[adr[31:2]] = w;
				end
				else
					dat_r <= word_at(adr);
				ack <= 1'b1;
			end
		end
	end
endmodule

// File: verilog/l1d_top.sv
/*
 * L1 data cache top: tag stage, data stage, control registers, bus unit
 */
`timescale 1ns/100ps

module l1d_top(
	input clk,
	input reset,
	input l1d_pkg::l1d_req_t req,
	output l1d_pkg::l1d_rsp_t rsp,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [31:0] wb_adr,
	output logic [3:0] wb_sel,
	output logic [31:0] wb_dat_w,
	input logic [31:0] wb_dat_r,
	input logic wb_ack);

	import l1d_pkg::*;

	l1d_lookup_t lookup;
	l1d_line_update_t update;
	l1d_miss_t miss;
	logic fill_busy;
	logic store_full;
	logic lru_update_en;
	logic lru_update_way;
	logic cache_enable;
	logic creg_we;
	l1d_creg_t creg_index;
	logic [31:0] creg_wdata;
	logic [31:0] creg_rdata;
	logic hit_event;
	logic miss_event;
	logic store_event;

	l1d_tag_stage tag_stage(.clk, .reset, .req, .lru_update_en, .lru_update_way,
		.update, .lookup);

	l1d_data_stage data_stage(.clk, .reset, .lookup, .update, .fill_busy, .store_full,
		.cache_enable, .creg_rdata, .rsp, .miss, .lru_update_en, .lru_update_way,
		.creg_we, .creg_index, .creg_wdata, .hit_event, .miss_event, .store_event);

	l1d_ctrl_regs ctrl_regs(.clk, .reset, .creg_we, .creg_index, .creg_wdata,
		.hit_event, .miss_event, .store_event, .cache_enable, .creg_rdata);

	// Memory side
	l1d_bus_unit bus_unit(.clk, .reset, .miss, .fill_busy, .store_full, .update,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_w, .wb_dat_r, .wb_ack);
endmodule

// File: verilog/l1d_bus_unit.sv
/*
 * Wishbone classic master: four-beat line fills, one-entry write-through
 * store buffer, and the tag and data updates for the arrays
 */
`timescale 1ns/100ps
`include "l1d_params.svh"

module l1d_bus_unit(
	input clk,
	input reset,
	input l1d_pkg::l1d_miss_t miss,
	output logic fill_busy,
	output logic store_full,
	output l1d_pkg::l1d_line_update_t update,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [31:0] wb_adr,
	output logic [3:0] wb_sel,
	output logic [31:0] wb_dat_w,
	input logic [31:0] wb_dat_r,
	input logic wb_ack);

	import l1d_pkg::*;

	typedef enum logic [1:0] {IDLE, FILL, STORE} bus_state_t;

	bus_state_t state;
	logic [$clog2(`L1D_LINE_WORDS) - 1:0] beat;
	logic fill_done;
	l1d_line_addr_t fill_line;
	l1d_way_t fill_way;
	l1d_set_t fill_set;
	l1d_tag_t fill_tag;
	l1d_line_t fill_buf;
	l1d_line_t fill_data;
	l1d_word_addr_t st_addr;
	logic [31:0] st_data;
	logic [3:0] st_sel;
	logic st_hit;
	l1d_way_t st_way;
	l1d_set_t st_set;
	l1d_tag_t st_tag;
	logic [`L1D_OFFSET_BITS - 3:0] st_word;
	logic [`L1D_LINE_BYTES - 1:0] st_line_mask;

	assign fill_set = fill_line[`L1D_SET_BITS - 1:0];
	assign fill_tag = fill_line[$bits(fill_line) - 1 -: `L1D_TAG_BITS];
	assign st_set = st_addr[`L1D_OFFSET_BITS - 2 +: `L1D_SET_BITS];
	assign st_tag = st_addr[$bits(st_addr) - 1 -: `L1D_TAG_BITS];
	assign st_word = st_addr[`L1D_OFFSET_BITS - 3:0];
	assign st_line_mask = {{(`L1D_LINE_BYTES - 4){1'b0}}, st_sel} << (st_word * 4);
	assign fill_done = state == FILL && wb_ack && &beat;

	assign wb_cyc = state != IDLE;
	assign wb_stb = state != IDLE;
	assign wb_we = state == STORE;
	assign wb_adr = (state == FILL) ? {fill_line, beat, 2'b00} : {st_addr, 2'b00};
	assign wb_sel = (state == FILL) ? 4'b1111 : st_sel;
	assign wb_dat_w = st_data;

	// Current beat merged into the words collected so far
	always_comb
	begin
		fill_data = fill_buf;
		fill_data[beat * 32 +: 32] = wb_dat_r;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			beat <= '0;
			fill_busy <= 1'b0;
			store_full <= 1'b0;
			update <= '0;
		end
		else
		begin
			update.tag_we <= 1'b0;
			update.data_we <= 1'b0;
			if (miss.fill_en)
				fill_busy <= 1'b1;
			if (miss.store_en)
				store_full <= 1'b1;

			case (state)
				IDLE:
				begin
					// Fills go ahead of a waiting store
					if (fill_busy)
						state <= FILL;
					else if (store_full)
						state <= STORE;
				end

				FILL:
				begin
					if (wb_ack)
						beat <= beat + 1'b1;
					if (fill_done)
					begin
						state <= IDLE;
						fill_busy <= 1'b0;
						update <= '{tag_we: 1'b1, data_we: 1'b1, way: fill_way, set: fill_set,
							tag: fill_tag, data: fill_data, mask: '1};
					end
				end

				default:
				begin
					if (wb_ack)
					begin
						state <= IDLE;
						store_full <= 1'b0;
						update <= '{tag_we: 1'b0, data_we: st_hit, way: st_way, set: st_set,
							tag: st_tag, data: {`L1D_LINE_WORDS{st_data}}, mask: st_line_mask};
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (miss.fill_en)
		begin
			fill_line <= miss.fill_line;
			fill_way <= miss.fill_way;
		end
		if (state == FILL && wb_ack)
			fill_buf <= fill_data;

		if (miss.store_en)
		begin
			st_addr <= miss.store_addr;
			st_data <= miss.store_data;
			st_sel <= miss.store_sel;
			st_hit <= miss.store_hit;
			st_way <= miss.store_way;
		end
		else if (fill_done && store_full && fill_set == st_set
			&& (fill_way == st_way || fill_tag == st_tag))
		begin
			// Fill evicted the buffered line or brought it in
			st_hit <= fill_tag == st_tag;
			st_way <= fill_way;
		end
	end

	// A beat holds its address and direction until ack
	assert property (@(posedge clk) disable iff (reset)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we));
endmodule

// File: verilog/l1d_ctrl_regs.sv
/*
 * Control registers: cache enable bit and hit, miss and store counters
 */
`timescale 1ns/100ps

module l1d_ctrl_regs(
	input clk,
	input reset,
	input logic creg_we,
	input l1d_pkg::l1d_creg_t creg_index,
	input logic [31:0] creg_wdata,
	input logic hit_event,
	input logic miss_event,
	input logic store_event,
	output logic cache_enable,
	output logic [31:0] creg_rdata);

	import l1d_pkg::*;

	logic [31:0] hit_count;
	logic [31:0] miss_count;
	logic [31:0] store_count;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			cache_enable <= 1'b1;
			hit_count <= '0;
			miss_count <= '0;
			store_count <= '0;
		end
		else
		begin
			if (hit_event)
				hit_count <= hit_count + 32'd1;
			if (miss_event)
				miss_count <= miss_count + 32'd1;
			if (store_event)
				store_count <= store_count + 32'd1;

			// Clear beats a same-cycle count
			if (creg_we)
			begin
				case (creg_index)
					CREG_ENABLE: cache_enable <= creg_wdata[0];
					CREG_HITS: hit_count <= '0;
					CREG_MISSES: miss_count <= '0;
					CREG_STORES: store_count <= '0;
				endcase
			end
		end
	end

	always_comb
	begin
		case (creg_index)
			CREG_ENABLE: creg_rdata = {31'd0, cache_enable};
			CREG_HITS: creg_rdata = hit_count;
			CREG_MISSES: creg_rdata = miss_count;
			default: creg_rdata = store_count;
		endcase
	end
endmodule

// File: verilog/l1d_data_stage.sv
/*
 * Data stage: hit detection, load extraction, store alignment, line data
 * array, rollback and miss decisions, and the second pipeline register
 */
`timescale 1ns/100ps
`include "l1d_params.svh"

module l1d_data_stage(
	input clk,
	input reset,
	input l1d_pkg::l1d_lookup_t lookup,
	input l1d_pkg::l1d_line_update_t update,
	input logic fill_busy,
	input logic store_full,
	input logic cache_enable,
	input logic [31:0] creg_rdata,
	output l1d_pkg::l1d_rsp_t rsp,
	output l1d_pkg::l1d_miss_t miss,
	output logic lru_update_en,
	output logic lru_update_way,
	output logic creg_we,
	output l1d_pkg::l1d_creg_t creg_index,
	output logic [31:0] creg_wdata,
	output logic hit_event,
	output logic miss_event,
	output logic store_event);

	import l1d_pkg::*;

	l1d_line_t data_mem[`L1D_WAYS][`L1D_SETS];
	l1d_req_t req;
	l1d_set_t set_idx;
	l1d_tag_t req_tag;
	logic [`L1D_WAYS - 1:0] way_hit_oh;
	l1d_way_t hit_way;
	logic cache_hit;
	logic is_load;
	logic is_store;
	logic near_miss;
	logic fill_pending;
	logic store_pending;
	logic load_ok;
	logic fill_start;
	logic store_ok;
	logic rollback;
	l1d_line_t hit_line;
	logic [31:0] hit_word;
	logic [31:0] load_value;
	logic [31:0] store_data;
	logic [3:0] store_sel;

	assign req = lookup.req;
	assign set_idx = req.addr[`L1D_OFFSET_BITS +: `L1D_SET_BITS];
	assign req_tag = req.addr[`L1D_ADDR_BITS - 1 -: `L1D_TAG_BITS];
	assign is_load = req.valid && req.op inside {OP_LOAD_B, OP_LOAD_H, OP_LOAD_W};
	assign is_store = req.valid && req.op inside {OP_STORE_B, OP_STORE_H, OP_STORE_W};

	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < `L1D_WAYS; w++)
		begin
			way_hit_oh[w] = lookup.valid[w] && lookup.tag[w] == req_tag;
			if (way_hit_oh[w])
				hit_way = l1d_way_t'(w);
		end
	end

	// Clearing enable makes every load look like a miss
	assign cache_hit = |way_hit_oh && cache_enable;

	// The set is being rewritten this cycle, so the lookup may be stale
	assign near_miss = (update.tag_we || update.data_we) && update.set == set_idx;

	// Include requests still sitting in our own output register
	assign fill_pending = fill_busy || miss.fill_en;
	assign store_pending = store_full || miss.store_en;

	// Hits wait for a buffered store, which may target the same line
	assign load_ok = is_load && cache_hit && !near_miss && !store_pending;
	assign fill_start = is_load && !cache_hit && cache_enable && !near_miss && !fill_pending;
	assign store_ok = is_store && !near_miss && !store_pending && !fill_pending;
	assign rollback = (is_load && !load_ok) || (is_store && !store_ok);

	assign hit_event = load_ok;
	assign miss_event = is_load && !cache_hit && !near_miss && !fill_pending;
	assign store_event = store_ok;
	assign lru_update_en = load_ok;
	assign lru_update_way = hit_way;

	// Control registers are selected by address bits 3:2
	assign creg_we = req.valid && req.op == OP_CREG_WRITE;
	assign creg_index = l1d_creg_t'(req.addr[3:2]);
	assign creg_wdata = req.wdata;

	assign hit_line = data_mem[hit_way][set_idx];
	assign hit_word = hit_line[req.addr[`L1D_OFFSET_BITS - 1:2] * 32 +: 32];

	always_comb
	begin
		case (req.op)
			OP_LOAD_B: load_value = {24'd0, hit_word[req.addr[1:0] * 8 +: 8]};
			OP_LOAD_H: load_value = {16'd0, hit_word[req.addr[1] * 16 +: 16]};
			default: load_value = hit_word;
		endcase
	end

	// Little endian lanes, data replicated so any lane holds it
	always_comb
	begin
		case (req.op)
			OP_STORE_B:
			begin
				store_sel = 4'b0001 << req.addr[1:0];
				store_data = {4{req.wdata[7:0]}};
			end

			OP_STORE_H:
			begin
				store_sel = req.addr[1] ? 4'b1100 : 4'b0011;
				store_data = {2{req.wdata[15:0]}};
			end

			default:
			begin
				store_sel = 4'b1111;
				store_data = req.wdata;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (update.data_we)
		begin
			for (int b = 0; b < `L1D_LINE_BYTES; b++)
			begin
				if (update.mask[b])
					data_mem[update.way][update.set][b * 8 +: 8] <= update.data[b * 8 +: 8];
			end
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rsp <= '0;
			miss <= '0;
		end
		else
		begin
			rsp.valid <= req.valid;
			rsp.status <= rollback ? ST_ROLLBACK : ST_OK;
			rsp.op <= req.op;
			if (req.op == OP_CREG_READ)
				rsp.rdata <= creg_rdata;
			else if (load_ok)
				rsp.rdata <= load_value;
			else
				rsp.rdata <= '0;

			miss.fill_en <= fill_start;
			miss.fill_line <= req.addr[`L1D_ADDR_BITS - 1:`L1D_OFFSET_BITS];
			miss.fill_way <= lookup.lru_way;
			miss.store_en <= store_ok;
			miss.store_addr <= req.addr[`L1D_ADDR_BITS - 1:2];
			miss.store_data <= store_data;
			miss.store_sel <= store_sel;
			miss.store_hit <= |way_hit_oh;
			miss.store_way <= hit_way;
		end
	end

	// A line lives in at most one way, which relies on the fill victim choice
	assert property (@(posedge clk) disable iff (reset)
		req.valid |-> $onehot0(way_hit_oh));
endmodule

// File: verilog/l1d_tag_stage.sv
/*
 * Tag stage: tag, valid and LRU arrays, with the first pipeline register
 */
`timescale 1ns/100ps
`include "l1d_params.svh"

module l1d_tag_stage(
	input clk,
	input reset,
	input l1d_pkg::l1d_req_t req,
	input logic lru_update_en,
	input logic lru_update_way,
	input l1d_pkg::l1d_line_update_t update,
	output l1d_pkg::l1d_lookup_t lookup);

	import l1d_pkg::*;

	l1d_tag_t tag_mem[`L1D_WAYS][`L1D_SETS];
	logic [`L1D_WAYS - 1:0] valid_mem[`L1D_SETS];
	logic lru_mem[`L1D_SETS];
	l1d_set_t req_set;
	l1d_set_t lookup_set;
	l1d_lookup_t next_lookup;

	assign req_set = req.addr[`L1D_OFFSET_BITS +: `L1D_SET_BITS];
	// LRU updates refer to the request now in the data stage
	assign lookup_set = lookup.req.addr[`L1D_OFFSET_BITS +: `L1D_SET_BITS];

	always_ff @(posedge clk)
	begin
		if (update.tag_we)
			tag_mem[update.way][update.set] <= update.tag;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			valid_mem <= '{default: '0};
			lru_mem <= '{default: 1'b0};
		end
		else
		begin
			if (lru_update_en)
				lru_mem[lookup_set] <= !lru_update_way;

			// A fill overrides a hit on the same set
			if (update.tag_we)
			begin
				valid_mem[update.set][update.way] <= 1'b1;
				lru_mem[update.set] <= !update.way;
			end
		end
	end

	// Bypass an update landing this cycle so the lookup never sees a stale tag
	always_comb
	begin
		next_lookup.req = req;
		for (int w = 0; w < `L1D_WAYS; w++)
		begin
			next_lookup.valid[w] = valid_mem[req_set][w];
			next_lookup.tag[w] = tag_mem[w][req_set];
			if (update.tag_we && update.way == w && update.set == req_set)
			begin
				next_lookup.valid[w] = 1'b1;
				next_lookup.tag[w] = update.tag;
			end
		end

		if (update.tag_we && update.set == req_set)
			next_lookup.lru_way = !update.way;
		else if (lru_update_en && lookup_set == req_set)
			next_lookup.lru_way = !lru_update_way;
		else
			next_lookup.lru_way = lru_mem[req_set];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			lookup <= '0;
		else
			lookup <= next_lookup;
	end

	// An update always names a known way and set
	assert property (@(posedge clk) disable iff (reset)
		(update.tag_we || update.data_we) |-> !$isunknown({update.way, update.set}));
endmodule

// File: verilog/l1d_pkg.sv
/*
 * Opcode, status and control register enums, core request and response,
 * and the records passed between tag stage, data stage and bus unit
 */
`include "l1d_params.svh"

package l1d_pkg;
	typedef enum logic [2:0] {
		OP_LOAD_B, OP_LOAD_H, OP_LOAD_W, OP_STORE_B,
		OP_STORE_H, OP_STORE_W, OP_CREG_READ, OP_CREG_WRITE
	} l1d_op_t;

	typedef enum logic {ST_OK, ST_ROLLBACK} l1d_status_t;

	typedef enum logic [1:0] {CREG_ENABLE, CREG_HITS, CREG_MISSES, CREG_STORES} l1d_creg_t;

	typedef logic [`L1D_TAG_BITS - 1:0] l1d_tag_t;
	typedef logic [`L1D_SET_BITS - 1:0] l1d_set_t;
	typedef logic [$clog2(`L1D_WAYS) - 1:0] l1d_way_t;
	typedef logic [`L1D_LINE_BITS - 1:0] l1d_line_t;
	typedef logic [`L1D_ADDR_BITS - `L1D_OFFSET_BITS - 1:0] l1d_line_addr_t;
	typedef logic [`L1D_ADDR_BITS - 3:0] l1d_word_addr_t;

	typedef struct packed {
		logic valid;
		l1d_op_t op;
		logic [`L1D_ADDR_BITS - 1:0] addr;
		logic [31:0] wdata;
	} l1d_req_t;

	typedef struct packed {
		logic valid;
		l1d_status_t status;
		l1d_op_t op;
		logic [31:0] rdata;
	} l1d_rsp_t;

	typedef struct packed {
		l1d_req_t req;
		logic [`L1D_WAYS - 1:0] valid;
		l1d_tag_t [`L1D_WAYS - 1:0] tag;
		l1d_way_t lru_way;
	} l1d_lookup_t;

	typedef struct packed {
		logic tag_we;
		logic data_we;
		l1d_way_t way;
		l1d_set_t set;
		l1d_tag_t tag;
		l1d_line_t data;
		logic [`L1D_LINE_BYTES - 1:0] mask;
	} l1d_line_update_t;

	// Store fields carry the residency seen when the store was accepted
	typedef struct packed {
		logic fill_en;
		l1d_line_addr_t fill_line;
		l1d_way_t fill_way;
		logic store_en;
		l1d_word_addr_t store_addr;
		logic [31:0] store_data;
		logic [3:0] store_sel;
		logic store_hit;
		l1d_way_t store_way;
	} l1d_miss_t;
endpackage

// File: verilog/l1d_params.svh
/*
 * Geometry of the L1 data cache and the widths derived from it
 */
`ifndef L1D_PARAMS_SVH
`define L1D_PARAMS_SVH

`define L1D_WAYS 2
`define L1D_SETS 16
`define L1D_LINE_BYTES 16
`define L1D_ADDR_BITS 32

// Derived widths
`define L1D_SET_BITS $clog2(`L1D_SETS)
`define L1D_OFFSET_BITS $clog2(`L1D_LINE_BYTES)
`define L1D_TAG_BITS (`L1D_ADDR_BITS - `L1D_SET_BITS - `L1D_OFFSET_BITS)
`define L1D_LINE_BITS (`L1D_LINE_BYTES * 8)
`define L1D_LINE_WORDS (`L1D_LINE_BYTES / 4)

`endif
